// File: compile.f
+incdir+verification
rtl/mem_pkg.sv
rtl/dual_port_ram.sv
rtl/ram_access.sv
rtl/mmio_regs.sv
rtl/access_router.sv
rtl/mem_system.sv
verification/tb_mem_system.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the memory stage testbench with Verilator and runs it.

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
    echo "cannot enter the project root"
    exit 1
fi

command -v verilator > /dev/null 2>&1
if [ $? -ne 0 ]; then
    echo "verilator not found in PATH"
    exit 1
fi

verilator --binary --timing --timescale 1ns/1ps -f compile.f \
    --top-module tb_mem_system -o sim_mem_system
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

output=$(./obj_dir/sim_mem_system 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "PASS: all tests" <<< "$output"; then
    exit 0
fi
exit 1

// File: verification/mem_model.svh
`ifndef MEM_MODEL_SVH
`define MEM_MODEL_SVH

// word 0 lane 0 sits behind the segment address and is never known.
logic [31:0] model_mem [0:255];
logic [15:0] model_seg = 16'd0;

// load result due in the cycle after the access that set it.
int          pend_seq = 0;
logic        pend_data_on = 1'b0;
logic [31:0] pend_data;
logic        pend_inst_on = 1'b0;
logic [31:0] pend_inst;

function automatic mem_pkg::region_e region_of(input logic [31:0] a);
    if (a == mem_pkg::seg_addr) begin
        return mem_pkg::region_seg;
    end else if (a == mem_pkg::uart_addr) begin
        return mem_pkg::region_uart;
    end
    return mem_pkg::region_ram;
endfunction

function automatic logic [31:0] expected_load(input logic [31:0] word,
                                              input mem_pkg::mem_width_e f3,
                                              input logic [1:0] off);
    logic [31:0] sh;
    sh = word >> {off, 3'b000}; // addressed byte moves down to bit 0.
    case (f3)
        mem_pkg::width_b:  return {{24{sh[7]}}, sh[7:0]};
        mem_pkg::width_bu: return {24'd0, sh[7:0]};
        mem_pkg::width_h:  return {{16{sh[15]}}, sh[15:0]};
        mem_pkg::width_hu: return {16'd0, sh[15:0]};
        default:           return word;
    endcase
endfunction

function automatic logic [31:0] merged_store(input logic [31:0] old, input logic [31:0] data,
                                             input mem_pkg::mem_width_e f3,
                                             input logic [1:0] off);
    logic [31:0] mask;
    case (f3)
        mem_pkg::width_b: mask = 32'h0000_00ff;
        mem_pkg::width_h: mask = 32'h0000_ffff;
        default:          mask = 32'hffff_ffff;
    endcase
    mask = mask << {off, 3'b000};
    return (old & ~mask) | ((data << {off, 3'b000}) & mask);
endfunction

`endif

// File: verification/tb_mem_system.sv
`timescale 1ns/1ps

module tb_mem_system;

    logic                   clk;
    logic                   arst_n;
    mem_pkg::mem_width_e    funct3;
    logic [31:0]            addr;
    logic [31:0]            writedata;
    logic                   writectrl;
    logic                   readctrl;
    logic [31:0]            readdata;
    logic [31:0]            addr_inst;
    logic [31:0]            readdata_inst;
    logic                   empty;
    logic [7:0]             uart_in;
    logic [7:0]             uart_out;
    logic                   wrreq;
    logic                   rdreq;
    logic [15:0]            seg_io;

    logic [31:0]            lfsr_state;
    logic                   fetch_en;
    logic                   pop_seen;
    logic [7:0]             rx_fifo [$];
    int                     port_errors = 0;
    int                     timeouts = 0;
    int                     data_errors = 0;
    int                     checks = 0;
    int                     taken_seq = 0;
    int                     checked_seq = 0;
    logic                   chk_now;
    logic                   chk_data_on;
    logic                   chk_inst_on;
    logic [31:0]            chk_data;
    logic [31:0]            chk_inst;

    `include "mem_model.svh"

    mem_system mem_system_i (
        .clk           (clk),
        .arst_n        (arst_n),
        .funct3        (funct3),
        .addr          (addr),
        .writedata     (writedata),
        .writectrl     (writectrl),
        .readctrl      (readctrl),
        .readdata      (readdata),
        .addr_inst     (addr_inst),
        .readdata_inst (readdata_inst),
        .empty         (empty),
        .uart_in       (uart_in),
        .uart_out      (uart_out),
        .wrreq         (wrreq),
        .rdreq         (rdreq),
        .seg_io        (seg_io)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // the receive FIFO hands out the popped byte in the next cycle.
    always @(posedge clk) begin
        pop_seen <= rdreq;
    end

    always @(posedge clk) begin
        chk_now = (taken_seq != pend_seq);
        if (chk_now) begin
            taken_seq   = pend_seq;
            chk_data_on = pend_data_on;
            chk_data    = pend_data;
            chk_inst_on = pend_inst_on;
            chk_inst    = pend_inst;
        end
        #30; // late in the cycle, after uart_in from the FIFO has moved.
        if (chk_now) begin
            if (chk_data_on && readdata !== chk_data) begin
                $display("** Error: readdata expected %h, got %h", chk_data, readdata);
                data_errors++;
            end
            if (chk_inst_on && readdata_inst !== chk_inst) begin
                $display("** Error: readdata_inst expected %h, got %h", chk_inst, readdata_inst);
                data_errors++;
            end
            checks++;
            checked_seq = taken_seq;
        end
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    function automatic mem_pkg::mem_width_e width_from(input logic [2:0] sel);
        case (sel)
            3'd0, 3'd5: return mem_pkg::width_b;
            3'd1:       return mem_pkg::width_h;
            3'd2:       return mem_pkg::width_w;
            3'd3, 3'd6: return mem_pkg::width_bu;
            default:    return mem_pkg::width_hu;
        endcase
    endfunction

    function automatic logic [31:0] aligned(input logic [31:0] a, input mem_pkg::mem_width_e f3);
        case (f3)
            mem_pkg::width_h, mem_pkg::width_hu: return {a[31:1], 1'b0};
            mem_pkg::width_w:                    return {a[31:2], 2'b00};
            default:                             return a;
        endcase
    endfunction

    task automatic rand_bits(input int n, output logic [31:0] v);
        v = 32'd0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
    endtask

    task automatic ram_addr(output logic [31:0] a);
        logic [31:0] rv;
        logic [7:0]  w;
        rand_bits(10, rv);
        w = rv[9:2];
        if (w < 8'd2) begin
            w = w + 8'd2; // words 0 and 1 overlap the peripherals.
        end
        a = {22'd0, w, rv[1:0]};
    endtask

    task automatic next_cycle();
        @(negedge clk);
        if (pop_seen && rx_fifo.size() > 0) begin
            uart_in = rx_fifo.pop_front();
        end
        empty = (rx_fifo.size() == 0);
    endtask

    task automatic idle_cycle();
        next_cycle();
        writectrl = 1'b0;
        readctrl  = 1'b0;
    endtask

    task automatic access(input logic we, input logic re, input mem_pkg::mem_width_e f3,
                          input logic [31:0] a, input logic [31:0] d);
        logic [31:0] exp;
        logic [31:0] rv;
        logic [7:0]  iw;
        logic        exp_wr;
        logic        exp_rd;
        next_cycle();
        funct3    = f3;
        addr      = a;
        writedata = d;
        writectrl = we;
        readctrl  = re;
        exp_wr = we && (region_of(a) == mem_pkg::region_uart);
        exp_rd = re && (region_of(a) == mem_pkg::region_uart) && !empty;
        case (region_of(a))
            mem_pkg::region_seg:  exp = {16'd0, model_seg};
            mem_pkg::region_uart: exp = empty ? mem_pkg::uart_empty_value : {24'd0, rx_fifo[0]};
            default:              exp = expected_load(model_mem[a[9:2]], f3, a[1:0]);
        endcase
        pend_data_on = re;
        pend_data    = exp;
        pend_inst_on = fetch_en;
        if (fetch_en) begin
            rand_bits(8, rv);
            iw = rv[7:0];
            if (iw < 8'd2) begin
                iw = iw + 8'd2;
            end
            if (iw == a[9:2]) begin
                iw = iw ^ 8'h01;
            end
            addr_inst = {22'd0, iw, 2'b00};
            pend_inst = model_mem[iw];
        end
        if (re || fetch_en) begin
            pend_seq++;
        end
        if (we && region_of(a) == mem_pkg::region_ram) begin
            model_mem[a[9:2]] = merged_store(model_mem[a[9:2]], d, f3, a[1:0]);
        end else if (we && region_of(a) == mem_pkg::region_seg) begin
            model_seg = d[15:0];
        end
        #10;
        if (wrreq !== exp_wr) begin
            $display("** Error: wrreq expected %h, got %h", exp_wr, wrreq);
            port_errors++;
        end
        if (exp_wr && uart_out !== d[7:0]) begin
            $display("** Error: uart_out expected %h, got %h", d[7:0], uart_out);
            port_errors++;
        end
        if (rdreq !== exp_rd) begin
            $display("** Error: rdreq expected %h, got %h", exp_rd, rdreq);
            port_errors++;
        end
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (checked_seq != pend_seq && n < 8) begin
            idle_cycle();
            n++;
        end
        if (checked_seq != pend_seq) begin
            $display("timeout: readdata comparison still pending after %0d cycles", n);
            timeouts++;
        end
    endtask

    initial begin
        logic [31:0]         a;
        logic [31:0]         d;
        logic [31:0]         rv;
        mem_pkg::mem_width_e f3;
        arst_n     = 1'b0;
        funct3     = mem_pkg::width_w;
        addr       = 32'd0;
        writedata  = 32'd0;
        writectrl  = 1'b0;
        readctrl   = 1'b0;
        addr_inst  = 32'd0;
        empty      = 1'b1;
        uart_in    = 8'd0;
        lfsr_state = 32'h916;
        fetch_en   = 1'b0;
        repeat (2) @(negedge clk);
        arst_n = 1'b1;

        rx_fifo.push_back(8'h5a); // a waiting byte makes rdreq depend on the read strobe alone.
        for (int i = 0; i < 4; i++) begin
            access(1'b0, 1'b0, mem_pkg::width_w, mem_pkg::uart_addr, 32'hffff_ffff);
            if (seg_io !== 16'd0) begin
                $display("** Error: seg_io expected %h, got %h", 16'd0, seg_io);
                port_errors++;
            end
        end
        rx_fifo.delete();

        for (int w = 2; w < 256; w++) begin
            rand_bits(32, d);
            access(1'b1, 1'b0, mem_pkg::width_w, {22'd0, w[7:0], 2'b00}, d);
        end
        fetch_en = 1'b1;

        for (int i = 0; i < 200; i++) begin
            ram_addr(a);
            rand_bits(32, d);
            rand_bits(2, rv);
            case (rv[1:0])
                2'd0:    access(1'b1, 1'b0, mem_pkg::width_w, aligned(a, mem_pkg::width_w), d);
                2'd2:    access(1'b1, 1'b1, mem_pkg::width_w, aligned(a, mem_pkg::width_w), d);
                default: access(1'b0, 1'b1, mem_pkg::width_w, aligned(a, mem_pkg::width_w), d);
            endcase
        end
        wait_drain();

        for (int i = 0; i < 300; i++) begin
            ram_addr(a);
            rand_bits(4, rv);
            if (rv[3]) begin
                f3 = rv[0] ? mem_pkg::width_h : mem_pkg::width_b;
                rand_bits(32, d);
                access(1'b1, 1'b0, f3, aligned(a, f3), d);
            end else begin
                f3 = width_from(rv[2:0]);
                access(1'b0, 1'b1, f3, aligned(a, f3), 32'd0);
            end
        end
        access(1'b1, 1'b0, mem_pkg::width_w, 32'h0000_00a0, 32'h8f7e_c3a5);
        for (int k = 0; k < 5; k++) begin
            for (int o = 0; o < 4; o++) begin
                f3 = width_from(k[2:0]);
                a  = 32'h0000_00a0 + o;
                if (aligned(a, f3) == a) begin
                    access(1'b0, 1'b1, f3, a, 32'd0);
                end
            end
        end
        wait_drain();

        for (int o = 1; o < 4; o++) begin
            rand_bits(8, rv);
            access(1'b1, 1'b0, mem_pkg::width_b, o, rv);
        end
        rand_bits(32, d);
        access(1'b1, 1'b0, mem_pkg::width_w, mem_pkg::seg_addr, d);
        idle_cycle();
        if (seg_io !== model_seg) begin
            $display("** Error: seg_io expected %h, got %h", model_seg, seg_io);
            port_errors++;
        end
        access(1'b0, 1'b1, mem_pkg::width_w, mem_pkg::seg_addr, 32'd0);
        for (int o = 1; o < 4; o++) begin
            access(1'b0, 1'b1, mem_pkg::width_bu, o, 32'd0);
        end
        wait_drain();

        for (int i = 0; i < 3; i++) begin
            rand_bits(32, d);
            access(1'b1, 1'b0, mem_pkg::width_w, mem_pkg::uart_addr, d);
        end
        for (int i = 0; i < 2; i++) begin
            access(1'b0, 1'b1, mem_pkg::width_w, mem_pkg::uart_addr, 32'd0);
        end
        for (int i = 0; i < 3; i++) begin
            rand_bits(8, rv);
            rx_fifo.push_back(rv[7:0]);
        end
        // other accesses leave the filled FIFO alone.
        access(1'b0, 1'b1, mem_pkg::width_w, 32'h0000_00a0, 32'd0);
        access(1'b0, 1'b1, mem_pkg::width_w, mem_pkg::seg_addr, 32'd0);
        access(1'b1, 1'b0, mem_pkg::width_w, mem_pkg::uart_addr, 32'h0000_0033);
        for (int i = 0; i < 4; i++) begin
            access(1'b0, 1'b1, mem_pkg::width_w, mem_pkg::uart_addr, 32'd0);
        end
        wait_drain();

        $display("checks %0d, readdata errors %0d, port errors %0d, timeouts %0d",
                 checks, data_errors, port_errors, timeouts);
        if (data_errors + port_errors + timeouts == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// File: rtl/mem_system.sv
`timescale 1ns/1ps

module mem_system (
    input  logic                        clk,
    input  logic                        arst_n,
    // data access from the load/store unit.
    input  mem_pkg::mem_width_e         funct3,
    input  logic [mem_pkg::xlen-1:0]    addr,
    input  logic [mem_pkg::xlen-1:0]    writedata,
    input  logic                        writectrl,
    input  logic                        readctrl,
    output logic [mem_pkg::xlen-1:0]    readdata,
    // instruction fetch.
    input  logic [mem_pkg::xlen-1:0]    addr_inst,
    output logic [mem_pkg::xlen-1:0]    readdata_inst,
    // UART FIFOs.
    input  logic                        empty,
    input  logic [7:0]                  uart_in,
    output logic [7:0]                  uart_out,
    output logic                        wrreq,
    output logic                        rdreq,
    // seven segment display.
    output logic [15:0]                 seg_io
);

    logic                       ram_we;
    logic                       seg_we;
    logic                       uart_wr;
    logic                       uart_rd;
    logic [mem_pkg::xlen-1:0]   load_data;
    logic [mem_pkg::xlen-1:0]   uart_rdata;

    access_router access_router_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .addr       (addr),
        .writectrl  (writectrl),
        .readctrl   (readctrl),
        .load_data  (load_data),
        .seg_io     (seg_io),
        .uart_rdata (uart_rdata),
        .ram_we     (ram_we),
        .seg_we     (seg_we),
        .uart_wr    (uart_wr),
        .uart_rd    (uart_rd),
        .readdata   (readdata)
    );

    ram_access ram_access_i (
        .clk           (clk),
        .arst_n        (arst_n),
        .funct3        (funct3),
        .addr          (addr),
        .writedata     (writedata),
        .ram_we        (ram_we),
        .addr_inst     (addr_inst),
        .readdata_inst (readdata_inst),
        .load_data     (load_data)
    );

    mmio_regs mmio_regs_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .seg_we     (seg_we),
        .uart_wr    (uart_wr),
        .uart_rd    (uart_rd),
        .writedata  (writedata),
        .empty      (empty),
        .uart_in    (uart_in),
        .seg_io     (seg_io),
        .uart_out   (uart_out),
        .wrreq      (wrreq),
        .rdreq      (rdreq),
        .uart_rdata (uart_rdata)
    );

endmodule

// File: rtl/access_router.sv
`timescale 1ns/1ps

module access_router (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic [mem_pkg::xlen-1:0]    addr,
    input  logic                        writectrl,
    input  logic                        readctrl,
    input  logic [mem_pkg::xlen-1:0]    load_data,
    input  logic [15:0]                 seg_io,
    input  logic [mem_pkg::xlen-1:0]    uart_rdata,
    output logic                        ram_we,
    output logic                        seg_we,
    output logic                        uart_wr,
    output logic                        uart_rd,
    output logic [mem_pkg::xlen-1:0]    readdata
);

    mem_pkg::region_e region;
    mem_pkg::region_e region_q;

    // anything that is not a peripheral address falls through to the RAM.
    always_comb begin
        if (addr == mem_pkg::seg_addr) begin
            region = mem_pkg::region_seg;
        end else if (addr == mem_pkg::uart_addr) begin
            region = mem_pkg::region_uart;
        end else begin
            region = mem_pkg::region_ram;
        end
    end

    assign ram_we  = writectrl && (region == mem_pkg::region_ram);
    assign seg_we  = writectrl && (region == mem_pkg::region_seg);
    assign uart_wr = writectrl && (region == mem_pkg::region_uart);
    assign uart_rd = readctrl && (region == mem_pkg::region_uart);

    // results of every source arrive one cycle after the address.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            region_q <= mem_pkg::region_ram;
        end else begin
            region_q <= region;
        end
    end

    always_comb begin
        case (region_q)
            mem_pkg::region_seg:  readdata = {16'd0, seg_io};
            mem_pkg::region_uart: readdata = uart_rdata;
            default:              readdata = load_data;
        endcase
    end

endmodule

// File: rtl/mmio_regs.sv
`timescale 1ns/1ps

module mmio_regs (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        seg_we,
    input  logic                        uart_wr,
    input  logic                        uart_rd,
    input  logic [mem_pkg::xlen-1:0]    writedata,
    input  logic                        empty,
    input  logic [7:0]                  uart_in,
    output logic [15:0]                 seg_io,
    output logic [7:0]                  uart_out,
    output logic                        wrreq,
    output logic                        rdreq,
    output logic [mem_pkg::xlen-1:0]    uart_rdata
);

    logic empty_q;

    // seven segment display holds the low halfword of the last write.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            seg_io <= 16'd0;
        end else if (seg_we) begin
            seg_io <= writedata[15:0];
        end
    end

    // transmit side is a straight strobe into the FIFO.
    assign uart_out = writedata[7:0];
    assign wrreq    = uart_wr;

    // only pop the receive FIFO when it actually holds a byte.
    assign rdreq = uart_rd & ~empty;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            empty_q <= 1'b1;
        end else if (uart_rd) begin
            empty_q <= empty; // the FIFO drives uart_in next cycle.
        end
    end

    always_comb begin
        if (empty_q) begin
            uart_rdata = mem_pkg::uart_empty_value;
        end else begin
            uart_rdata = {24'd0, uart_in};
        end
    end

endmodule

// File: rtl/ram_access.sv
`timescale 1ns/1ps

module ram_access (
    input  logic                        clk,
    input  logic                        arst_n,
    input  mem_pkg::mem_width_e         funct3,
    input  logic [mem_pkg::xlen-1:0]    addr,
    input  logic [mem_pkg::xlen-1:0]    writedata,
    input  logic                        ram_we,
    input  logic [mem_pkg::xlen-1:0]    addr_inst,
    output logic [mem_pkg::xlen-1:0]    readdata_inst,
    output logic [mem_pkg::xlen-1:0]    load_data
);

    logic [3:0]                 byte_we;
    logic [3:0]                 lane_mask;
    logic [mem_pkg::xlen-1:0]   store_word;
    logic [mem_pkg::xlen-1:0]   ram_word;
    mem_pkg::mem_width_e        funct3_q;
    logic [1:0]                 offset_q;
    logic [7:0]                 load_byte;
    logic [15:0]                load_half;

    // replicate narrow store data so every lane carries the right bits.
    always_comb begin
        case (funct3)
            mem_pkg::width_b: begin
                store_word = {4{writedata[7:0]}};
                lane_mask  = 4'b0001 << addr[1:0];
            end
            mem_pkg::width_h: begin
                store_word = {2{writedata[15:0]}};
                lane_mask  = addr[1] ? 4'b1100 : 4'b0011;
            end
            default: begin
                store_word = writedata;
                lane_mask  = 4'b1111;
            end
        endcase
    end

    assign byte_we = ram_we ? lane_mask : 4'b0000;

    dual_port_ram dual_port_ram_i (
        .clk            (clk),
        .inst_word_addr (addr_inst[mem_pkg::ram_aw+1:2]),
        .data_word_addr (addr[mem_pkg::ram_aw+1:2]),
        .byte_we        (byte_we),
        .wdata          (store_word),
        .inst_rdata     (readdata_inst),
        .data_rdata     (ram_word)
    );

    // width and offset of the access whose word arrives next cycle.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            funct3_q <= mem_pkg::width_w;
            offset_q <= 2'd0;
        end else begin
            funct3_q <= funct3;
            offset_q <= addr[1:0];
        end
    end

    // little endian lane select.
    always_comb begin
        case (offset_q)
            2'd0:    load_byte = ram_word[7:0];
            2'd1:    load_byte = ram_word[15:8];
            2'd2:    load_byte = ram_word[23:16];
            default: load_byte = ram_word[31:24];
        endcase
        load_half = offset_q[1] ? ram_word[31:16] : ram_word[15:0];
    end

    always_comb begin
        case (funct3_q)
            mem_pkg::width_b:  load_data = {{24{load_byte[7]}}, load_byte};
            mem_pkg::width_bu: load_data = {24'd0, load_byte};
            mem_pkg::width_h:  load_data = {{16{load_half[15]}}, load_half};
            mem_pkg::width_hu: load_data = {16'd0, load_half};
            default:           load_data = ram_word;
        endcase
    end

endmodule

// File: rtl/dual_port_ram.sv
`timescale 1ns/1ps

module dual_port_ram (
    input  logic                        clk,
    input  logic [mem_pkg::ram_aw-1:0]  inst_word_addr,
    input  logic [mem_pkg::ram_aw-1:0]  data_word_addr,
    input  logic [3:0]                  byte_we,
    input  logic [mem_pkg::xlen-1:0]    wdata,
    output logic [mem_pkg::xlen-1:0]    inst_rdata,
    output logic [mem_pkg::xlen-1:0]    data_rdata
);

    logic [mem_pkg::xlen-1:0] mem [0:mem_pkg::ram_words-1];

    // instruction fetch port, read only.
    always_ff @(posedge clk) begin
        inst_rdata <= mem[inst_word_addr];
    end

    // data port reads the stored word before the enabled lanes are written.
    always_ff @(posedge clk) begin
        data_rdata <= mem[data_word_addr];
        for (int i = 0; i < 4; i++) begin
            if (byte_we[i]) begin
                mem[data_word_addr][8*i +: 8] <= wdata[8*i +: 8];
            end
        end
    end

endmodule

// File: rtl/mem_pkg.sv
package mem_pkg;

    // data path and address width.
    localparam int xlen = 32;

    // word address bits of the shared RAM, taken from addr[16:2].
    localparam int ram_aw = 15;
    localparam int ram_words = 1 << ram_aw;

    // memory mapped peripheral byte addresses.
    localparam logic [xlen-1:0] seg_addr = 32'h0000_0000;
    localparam logic [xlen-1:0] uart_addr = 32'h0000_0004;

    // returned by a UART read that finds the receive FIFO empty.
    localparam logic [xlen-1:0] uart_empty_value = 32'hffff_ffff;

    // load and store widths, encoded exactly as funct3.
    typedef enum logic [2:0] {
        width_b  = 3'b000,
        width_h  = 3'b001,
        width_w  = 3'b010,
        width_bu = 3'b100,
        width_hu = 3'b101
    } mem_width_e;

    // target of a data access after address decode.
    typedef enum logic [1:0] {
        region_ram  = 2'd0,
        region_seg  = 2'd1,
        region_uart = 2'd2
    } region_e;

endpackage
